/* source/core_block_pkg.sv */
package core_block_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Core data word and byte strobes
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Core word address
  localparam int ADDR_W = 16;

  // Word offset within the broadcast region, regions of up to 256 words
  localparam int MSG_ADDR_W = 8;

  //////////////////////////////
  // Register and status map
  //////////////////////////////

  localparam logic [1:0] STAT_CFG     = 2'd0;
  localparam logic [1:0] STAT_SLOTS   = 2'd1;
  localparam logic [1:0] STAT_DEBUG_L = 2'd2;
  localparam logic [1:0] STAT_DEBUG_H = 2'd3;

  //////////////////////////////
  // FIFO payloads
  //////////////////////////////

  // Broadcast message, offset on top as on the inter-core bus
  typedef struct packed {
    logic [MSG_ADDR_W-1:0] offset;
    logic [STRB_W-1:0]     strb;
    logic [DATA_W-1:0]     data;
  } bc_msg_t;

  // Slot report from the core
  typedef struct packed {
    logic [31:0] slot;
  } slot_rpt_t;

endpackage

/* source/payload_fifo.sv */
`timescale 1ns/1ps

module payload_fifo #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     core_rst,
  input  logic     push,
  input  PAYLOAD_T push_data,
  output logic     full,
  input  logic     pop,
  output PAYLOAD_T pop_data,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  PAYLOAD_T         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Pointer step with wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Push ignored when full, pop ignored when empty
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/bc_region_encoder.sv */
`timescale 1ns/1ps

module bc_region_encoder #(
  parameter int DMEM_WORDS      = 1024,
  parameter int BC_REGION_WORDS = 64
) (
  input  logic                                core_mem_en,
  input  logic                                core_mem_wen,
  input  logic [core_block_pkg::STRB_W-1:0]   core_mem_strb,
  input  logic [core_block_pkg::ADDR_W-1:0]   core_mem_addr,
  input  logic [core_block_pkg::DATA_W-1:0]   core_mem_wr_data,
  output logic                                core_mem_ready,
  output logic                                msg_push,
  output core_block_pkg::bc_msg_t             msg_push_data,
  input  logic                                msg_full
);

  // First word of the broadcast region at the top of data memory
  localparam int BC_BASE = DMEM_WORDS - BC_REGION_WORDS;

  logic                              accepted;
  logic                              in_region;
  logic [core_block_pkg::ADDR_W-1:0] region_offset;

  //////////////////////////////
  // Back-pressure
  //////////////////////////////

  // Every access stalls while the queue is full, not only broadcast writes,
  // so the core never has to tell its accesses apart
  assign core_mem_ready = !msg_full;
  assign accepted       = core_mem_en && core_mem_ready;

  //////////////////////////////
  // Message build
  //////////////////////////////

  assign in_region     = (core_mem_addr >= core_block_pkg::ADDR_W'(BC_BASE));
  assign region_offset = core_mem_addr - core_block_pkg::ADDR_W'(BC_BASE);

  assign msg_push = accepted && core_mem_wen && in_region;

  always_comb begin
    msg_push_data.offset = region_offset[core_block_pkg::MSG_ADDR_W-1:0];
    msg_push_data.strb   = core_mem_strb;
    msg_push_data.data   = core_mem_wr_data;
  end

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
  parameter int DMEM_WORDS      = 1024,
  parameter int BC_REGION_WORDS = 64
) (
  input  logic                                clk,
  input  logic                                core_rst,
  input  logic                                core_mem_en,
  input  logic                                core_mem_wen,
  input  logic [core_block_pkg::STRB_W-1:0]   core_mem_strb,
  input  logic [core_block_pkg::ADDR_W-1:0]   core_mem_addr,
  input  logic [core_block_pkg::DATA_W-1:0]   core_mem_wr_data,
  input  logic                                core_mem_ready,
  output logic [core_block_pkg::DATA_W-1:0]   core_mem_rd_data,
  output logic                                core_mem_rd_valid,
  input  core_block_pkg::bc_msg_t             bc_msg_in,
  input  logic                                bc_msg_in_valid
);

  localparam int IDX_W   = $clog2(DMEM_WORDS);
  localparam int BC_BASE = DMEM_WORDS - BC_REGION_WORDS;

  logic [core_block_pkg::DATA_W-1:0] mem [DMEM_WORDS];

  logic             core_accept;
  logic             core_wr;
  logic             core_rd;
  logic [IDX_W-1:0] core_idx;
  logic [IDX_W-1:0] msg_idx;

  assign core_accept = core_mem_en && core_mem_ready;
  assign core_wr     = core_accept && core_mem_wen;
  assign core_rd     = core_accept && !core_mem_wen;
  assign core_idx    = core_mem_addr[IDX_W-1:0];

  // Incoming offsets are relative to the region base
  assign msg_idx = IDX_W'(BC_BASE) + IDX_W'(bc_msg_in.offset);

  //////////////////////////////
  // Byte-strobed writes
  //////////////////////////////

  // Core bytes are assigned last so they win on a same-word collision
  always_ff @(posedge clk) begin
    for (int b = 0; b < core_block_pkg::STRB_W; b++) begin
      if (bc_msg_in_valid && bc_msg_in.strb[b]) begin
        mem[msg_idx][b*8 +: 8] <= bc_msg_in.data[b*8 +: 8];
      end
      if (core_wr && core_mem_strb[b]) begin
        mem[core_idx][b*8 +: 8] <= core_mem_wr_data[b*8 +: 8];
      end
    end
  end

  //////////////////////////////
  // Registered read
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (core_rd) begin
      core_mem_rd_data <= mem[core_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      core_mem_rd_valid <= 1'b0;
    end else begin
      core_mem_rd_valid <= core_rd;
    end
  end

endmodule

/* source/block_status_ctrl.sv */
`timescale 1ns/1ps

module block_status_ctrl #(
  parameter int SLOT_FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              core_rst,
  // APB slave
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [3:0]                        paddr,
  input  logic [core_block_pkg::DATA_W-1:0] pwdata,
  output logic [core_block_pkg::DATA_W-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr,
  // Slot reports from the core
  input  logic                              slot_wr_valid,
  input  logic [31:0]                       slot_wr_data,
  output logic                              slot_wr_ready,
  input  logic                              msg_fifo_full,
  // Status stream to the wrapper
  output logic                              core_status_valid,
  output logic [1:0]                        core_status_addr,
  output logic [31:0]                       core_status_data,
  input  logic                              core_status_ready,
  // Configuration to the core
  output logic [7:0]                        core_id,
  output logic [7:0]                        max_slot_count,
  output logic [15:0]                       bc_region_size,
  output logic [31:0]                       active_slots,
  output logic [63:0]                       debug_in
);

  logic                              apb_access;
  logic                              misaligned;
  logic [core_block_pkg::DATA_W-1:0] reg_rd_data;

  core_block_pkg::slot_rpt_t slot_in;
  core_block_pkg::slot_rpt_t slot_head;
  logic                      slot_full;
  logic                      slot_empty;
  logic                      slot_pop;

  //////////////////////////////
  // APB register file
  //////////////////////////////

  assign apb_access = psel && penable;
  assign misaligned = (paddr[1:0] != 2'b00);
  assign pready     = 1'b1;
  assign pslverr    = apb_access && misaligned;

  // core_rst clears every register, ACTIVE_SLOTS included
  always_ff @(posedge clk) begin
    if (core_rst) begin
      bc_region_size <= '0;
      max_slot_count <= '0;
      core_id        <= '0;
      active_slots   <= '0;
      debug_in       <= '0;
    end else if (apb_access && pwrite && !misaligned) begin
      case (paddr[3:2])
        core_block_pkg::STAT_CFG: begin
          bc_region_size <= pwdata[15:0];
          max_slot_count <= pwdata[23:16];
          core_id        <= pwdata[31:24];
        end
        core_block_pkg::STAT_SLOTS:   active_slots    <= pwdata;
        core_block_pkg::STAT_DEBUG_L: debug_in[31:0]  <= pwdata;
        core_block_pkg::STAT_DEBUG_H: debug_in[63:32] <= pwdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rd_data = '0;
    case (paddr[3:2])
      core_block_pkg::STAT_CFG:     reg_rd_data = {core_id, max_slot_count, bc_region_size};
      core_block_pkg::STAT_SLOTS:   reg_rd_data = active_slots;
      core_block_pkg::STAT_DEBUG_L: reg_rd_data = debug_in[31:0];
      core_block_pkg::STAT_DEBUG_H: reg_rd_data = debug_in[63:32];
      default: ;
    endcase
  end

  assign prdata = misaligned ? '0 : reg_rd_data;

  //////////////////////////////
  // Slot report queue
  //////////////////////////////

  assign slot_in.slot  = slot_wr_data;
  assign slot_wr_ready = !slot_full;
  assign slot_pop      = core_status_valid && core_status_ready && !slot_empty;

  payload_fifo #(
    .PAYLOAD_T (core_block_pkg::slot_rpt_t),
    .DEPTH     (SLOT_FIFO_DEPTH)
  ) u_slot_fifo (
    .clk       (clk),
    .core_rst  (core_rst),
    .push      (slot_wr_valid && slot_wr_ready),
    .push_data (slot_in),
    .full      (slot_full),
    .pop       (slot_pop),
    .pop_data  (slot_head),
    .empty     (slot_empty)
  );

  // Queued reports first, idle word otherwise
  assign core_status_valid = !core_rst;
  assign core_status_addr  = slot_empty ? core_block_pkg::STAT_CFG : core_block_pkg::STAT_SLOTS;
  assign core_status_data  = slot_empty ? {22'd0, slot_full, msg_fifo_full, core_id}
                                        : slot_head.slot;

endmodule

/* source/core_block.sv */
`timescale 1ns/1ps

module core_block #(
  parameter int DMEM_WORDS      = 1024,
  parameter int BC_REGION_WORDS = 64,
  parameter int MSG_FIFO_DEPTH  = 4,
  parameter int SLOT_FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              core_rst,
  // APB slave
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [3:0]                        paddr,
  input  logic [core_block_pkg::DATA_W-1:0] pwdata,
  output logic [core_block_pkg::DATA_W-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr,
  // Core memory port
  input  logic                              core_mem_en,
  input  logic                              core_mem_wen,
  input  logic [core_block_pkg::STRB_W-1:0] core_mem_strb,
  input  logic [core_block_pkg::ADDR_W-1:0] core_mem_addr,
  input  logic [core_block_pkg::DATA_W-1:0] core_mem_wr_data,
  output logic                              core_mem_ready,
  output logic [core_block_pkg::DATA_W-1:0] core_mem_rd_data,
  output logic                              core_mem_rd_valid,
  // Slot reports
  input  logic                              slot_wr_valid,
  input  logic [31:0]                       slot_wr_data,
  output logic                              slot_wr_ready,
  // Broadcast messages
  input  core_block_pkg::bc_msg_t           bc_msg_in,
  input  logic                              bc_msg_in_valid,
  output core_block_pkg::bc_msg_t           bc_msg_out,
  output logic                              bc_msg_out_valid,
  input  logic                              bc_msg_out_ready,
  // Status stream
  output logic                              core_status_valid,
  output logic [1:0]                        core_status_addr,
  output logic [31:0]                       core_status_data,
  input  logic                              core_status_ready,
  // Configuration outputs
  output logic [7:0]                        core_id,
  output logic [7:0]                        max_slot_count,
  output logic [15:0]                       bc_region_size,
  output logic [31:0]                       active_slots,
  output logic [63:0]                       debug_in
);

  core_block_pkg::bc_msg_t msg_push_data;
  logic                    msg_push;
  logic                    msg_full;
  logic                    msg_empty;

  //////////////////////////////
  // Control
  //////////////////////////////

  block_status_ctrl #(
    .SLOT_FIFO_DEPTH (SLOT_FIFO_DEPTH)
  ) u_status_ctrl (
    .clk               (clk),
    .core_rst          (core_rst),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .pready            (pready),
    .pslverr           (pslverr),
    .slot_wr_valid     (slot_wr_valid),
    .slot_wr_data      (slot_wr_data),
    .slot_wr_ready     (slot_wr_ready),
    .msg_fifo_full     (msg_full),
    .core_status_valid (core_status_valid),
    .core_status_addr  (core_status_addr),
    .core_status_data  (core_status_data),
    .core_status_ready (core_status_ready),
    .core_id           (core_id),
    .max_slot_count    (max_slot_count),
    .bc_region_size    (bc_region_size),
    .active_slots      (active_slots),
    .debug_in          (debug_in)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  bc_region_encoder #(
    .DMEM_WORDS      (DMEM_WORDS),
    .BC_REGION_WORDS (BC_REGION_WORDS)
  ) u_bc_encoder (
    .core_mem_en      (core_mem_en),
    .core_mem_wen     (core_mem_wen),
    .core_mem_strb    (core_mem_strb),
    .core_mem_addr    (core_mem_addr),
    .core_mem_wr_data (core_mem_wr_data),
    .core_mem_ready   (core_mem_ready),
    .msg_push         (msg_push),
    .msg_push_data    (msg_push_data),
    .msg_full         (msg_full)
  );

  // Outgoing queue, head shown directly on the broadcast bus
  payload_fifo #(
    .PAYLOAD_T (core_block_pkg::bc_msg_t),
    .DEPTH     (MSG_FIFO_DEPTH)
  ) u_msg_fifo (
    .clk       (clk),
    .core_rst  (core_rst),
    .push      (msg_push),
    .push_data (msg_push_data),
    .full      (msg_full),
    .pop       (bc_msg_out_valid && bc_msg_out_ready),
    .pop_data  (bc_msg_out),
    .empty     (msg_empty)
  );

  assign bc_msg_out_valid = !msg_empty;

  data_mem #(
    .DMEM_WORDS      (DMEM_WORDS),
    .BC_REGION_WORDS (BC_REGION_WORDS)
  ) u_data_mem (
    .clk               (clk),
    .core_rst          (core_rst),
    .core_mem_en       (core_mem_en),
    .core_mem_wen      (core_mem_wen),
    .core_mem_strb     (core_mem_strb),
    .core_mem_addr     (core_mem_addr),
    .core_mem_wr_data  (core_mem_wr_data),
    .core_mem_ready    (core_mem_ready),
    .core_mem_rd_data  (core_mem_rd_data),
    .core_mem_rd_valid (core_mem_rd_valid),
    .bc_msg_in         (bc_msg_in),
    .bc_msg_in_valid   (bc_msg_in_valid)
  );

endmodule

/* verif/core_block_tb.sv */
`timescale 1ns/1ps

module core_block_tb;

  localparam int DMEM_WORDS      = 1024;
  localparam int BC_REGION_WORDS = 64;
  localparam int MSG_FIFO_DEPTH  = 4;
  localparam int SLOT_FIFO_DEPTH = 4;
  localparam int BC_BASE         = DMEM_WORDS - BC_REGION_WORDS;
  localparam int TIMEOUT         = 200;

  logic                    clk;
  logic                    core_rst;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [3:0]              paddr;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    core_mem_en;
  logic                    core_mem_wen;
  logic [3:0]              core_mem_strb;
  logic [15:0]             core_mem_addr;
  logic [31:0]             core_mem_wr_data;
  logic                    core_mem_ready;
  logic [31:0]             core_mem_rd_data;
  logic                    core_mem_rd_valid;
  logic                    slot_wr_valid;
  logic [31:0]             slot_wr_data;
  logic                    slot_wr_ready;
  core_block_pkg::bc_msg_t bc_msg_in;
  logic                    bc_msg_in_valid;
  core_block_pkg::bc_msg_t bc_msg_out;
  logic                    bc_msg_out_valid;
  logic                    bc_msg_out_ready;
  logic                    core_status_valid;
  logic [1:0]              core_status_addr;
  logic [31:0]             core_status_data;
  logic                    core_status_ready;
  logic [7:0]              core_id;
  logic [7:0]              max_slot_count;
  logic [15:0]             bc_region_size;
  logic [31:0]             active_slots;
  logic [63:0]             debug_in;

  // Reference state
  logic [31:0]             model [DMEM_WORDS];
  core_block_pkg::bc_msg_t exp_msgs [$];
  logic [31:0]             exp_slots [$];
  logic [31:0]             rng_state = 32'h29f3_9a55;
  int                      err_count = 0;
  int                      test_count = 0;
  int                      test_err_start = 0;
  int                      msgs_seen = 0;
  event                    timeout_hit;

  core_block #(
    .DMEM_WORDS      (DMEM_WORDS),
    .BC_REGION_WORDS (BC_REGION_WORDS),
    .MSG_FIFO_DEPTH  (MSG_FIFO_DEPTH),
    .SLOT_FIFO_DEPTH (SLOT_FIFO_DEPTH)
  ) u_dut (.*);

  always #20 clk = ~clk;

  ////////////////////////////////
  // Reference functions
  ////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // Offset relative to the first word of the broadcast region
  function automatic core_block_pkg::bc_msg_t expected_msg(input logic [15:0] addr,
                                                           input logic [3:0]  strb,
                                                           input logic [31:0] data);
    core_block_pkg::bc_msg_t m;
    logic [15:0]             off;
    off      = addr - 16'(BC_BASE);
    m.offset = off[core_block_pkg::MSG_ADDR_W-1:0];
    m.strb   = strb;
    m.data   = data;
    return m;
  endfunction

  function automatic logic [31:0] idle_word(input logic [7:0] id, input logic msg_full,
                                            input logic slot_full);
    logic [31:0] w;
    w      = '0;
    w[7:0] = id;
    w[8]   = msg_full;
    w[9]   = slot_full;
    return w;
  endfunction

  ////////////////////////////////
  // Reporting
  ////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("[%0t ns] Failure: %s", $time, what);
    err_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("[%0t ns] Timeout while waiting for %s", $time, what);
    err_count++;
    -> timeout_hit;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %0d %s done with %0d errors", test_count, name,
             err_count - test_err_start);
    test_err_start = err_count;
  endtask

  // Stop the run on any timeout
  initial begin : timeout_watch
    @(timeout_hit);
    $display("Stopped after %0d tests, error count %0d", test_count, err_count);
    $display("Errors found");
    $finish;
  end

  // Compare every outgoing message with the oldest pending one
  always @(posedge clk) begin
    if (!core_rst && bc_msg_out_valid && bc_msg_out_ready) begin
      if (exp_msgs.size() == 0) begin
        report_failure("message on bc_msg_out while none was pending");
      end else begin
        if (bc_msg_out !== exp_msgs[0]) begin
          report_mismatch("bc_msg_out", exp_msgs[0], bc_msg_out);
        end
        void'(exp_msgs.pop_front());
      end
      msgs_seen++;
    end
  end

  ////////////////////////////////
  // Drivers
  ////////////////////////////////

  // All tasks start and end 2 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int cycles;
    cycles  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2 penable = 1'b1;
    @(posedge clk);
    while (pready !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("APB pready");
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic core_access(input logic wen, input logic [3:0] strb, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles           = 0;
    rdata            = '0;
    core_mem_en      = 1'b1;
    core_mem_wen     = wen;
    core_mem_strb    = strb;
    core_mem_addr    = addr;
    core_mem_wr_data = wdata;
    @(posedge clk);
    while (core_mem_ready !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("core_mem_ready");
      @(posedge clk);
    end
    // Accepted on this edge
    if (core_mem_rd_valid !== 1'b0) begin
      report_mismatch("core_mem_rd_valid", 0, core_mem_rd_valid);
    end
    if (wen) begin
      model[addr] = merge_bytes(model[addr], wdata, strb);
      if (addr >= BC_BASE) begin
        exp_msgs.push_back(expected_msg(addr, strb, wdata));
      end
    end
    #2;
    core_mem_en  = 1'b0;
    core_mem_wen = 1'b0;
    if (!wen) begin
      @(posedge clk);
      if (core_mem_rd_valid !== 1'b1) begin
        report_failure("core_mem_rd_valid not high 1 cycle after read acceptance");
      end
      rdata = core_mem_rd_data;
      #2;
    end
  endtask

  task automatic wait_msgs_drained();
    int cycles;
    cycles = 0;
    while (exp_msgs.size() != 0) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("pending broadcast messages to leave");
      @(posedge clk);
      #2;
    end
  endtask

  task automatic slot_push(input logic [31:0] data);
    int cycles;
    cycles        = 0;
    slot_wr_valid = 1'b1;
    slot_wr_data  = data;
    @(posedge clk);
    while (slot_wr_ready !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("slot_wr_ready");
      @(posedge clk);
    end
    exp_slots.push_back(data);
    #2 slot_wr_valid = 1'b0;
  endtask

  ////////////////////////////////
  // Test sequence
  ////////////////////////////////

  initial begin : main_seq
    logic [31:0] rd;
    logic        err;
    logic [31:0] cfg;
    logic [31:0] vals [4];
    logic [31:0] wd;
    logic [3:0]  st;
    logic [15:0] addrs [8];
    int          seen_start;
    int          cycles;

    clk               = 1'b0;
    core_rst          = 1'b1;
    psel              = 1'b0;
    penable           = 1'b0;
    pwrite            = 1'b0;
    paddr             = '0;
    pwdata            = '0;
    core_mem_en       = 1'b0;
    core_mem_wen      = 1'b0;
    core_mem_strb     = '0;
    core_mem_addr     = '0;
    core_mem_wr_data  = '0;
    slot_wr_valid     = 1'b0;
    slot_wr_data      = '0;
    bc_msg_in         = '0;
    bc_msg_in_valid   = 1'b0;
    bc_msg_out_ready  = 1'b1;
    core_status_ready = 1'b0;

    repeat (5) @(posedge clk);
    #2;
    if (core_status_valid !== 1'b0) report_mismatch("core_status_valid", 0, core_status_valid);
    core_rst = 1'b0;
    @(posedge clk);
    #2;

    // 1. APB registers
    if (core_status_valid !== 1'b1) report_mismatch("core_status_valid", 1, core_status_valid);
    if (core_mem_rd_valid !== 1'b0) report_mismatch("core_mem_rd_valid", 0, core_mem_rd_valid);
    if (bc_msg_out_valid !== 1'b0) report_mismatch("bc_msg_out_valid", 0, bc_msg_out_valid);
    if (pslverr !== 1'b0) report_mismatch("pslverr", 0, pslverr);
    for (int r = 0; r < 4; r++) begin
      apb_xfer(1'b0, 4'(r * 4), '0, rd, err);
      if (rd !== 32'd0) report_mismatch("prdata", 0, rd);
    end
    for (int r = 0; r < 4; r++) begin
      vals[r] = next_rand();
      apb_xfer(1'b1, 4'(r * 4), vals[r], rd, err);
      if (err !== 1'b0) report_mismatch("pslverr", 0, err);
    end
    for (int r = 0; r < 4; r++) begin
      apb_xfer(1'b0, 4'(r * 4), '0, rd, err);
      if (rd !== vals[r]) report_mismatch("prdata", vals[r], rd);
    end
    if (bc_region_size !== vals[0][15:0]) report_mismatch("bc_region_size", vals[0][15:0],
                                                          bc_region_size);
    if (max_slot_count !== vals[0][23:16]) report_mismatch("max_slot_count", vals[0][23:16],
                                                           max_slot_count);
    if (core_id !== vals[0][31:24]) report_mismatch("core_id", vals[0][31:24], core_id);
    if (active_slots !== vals[1]) report_mismatch("active_slots", vals[1], active_slots);
    if (debug_in !== {vals[3], vals[2]}) report_mismatch("debug_in", {vals[3], vals[2]},
                                                         debug_in);
    // Misaligned access is dropped with a slave error
    apb_xfer(1'b1, 4'h6, ~vals[1], rd, err);
    if (err !== 1'b1) report_mismatch("pslverr", 1, err);
    apb_xfer(1'b0, 4'h5, '0, rd, err);
    if (err !== 1'b1) report_mismatch("pslverr", 1, err);
    if (rd !== 32'd0) report_mismatch("prdata", 0, rd);
    apb_xfer(1'b0, 4'h4, '0, rd, err);
    if (rd !== vals[1]) report_mismatch("prdata", vals[1], rd);
    core_rst = 1'b1;
    @(posedge clk);
    #2 core_rst = 1'b0;
    if (active_slots !== 32'd0) report_mismatch("active_slots", 0, active_slots);
    apb_xfer(1'b0, 4'h4, '0, rd, err);
    if (rd !== 32'd0) report_mismatch("prdata", 0, rd);
    finish_test("apb registers");

    // 2. Local memory below the broadcast region
    seen_start = msgs_seen;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 16'(next_rand() % BC_BASE);
      core_access(1'b1, 4'hf, addrs[i], next_rand(), rd);
      wd = next_rand();
      st = wd[3:0];
      core_access(1'b1, st, addrs[i], next_rand(), rd);
    end
    for (int i = 0; i < 8; i++) begin
      core_access(1'b0, 4'h0, addrs[i], '0, rd);
      if (rd !== model[addrs[i]]) report_mismatch("core_mem_rd_data", model[addrs[i]], rd);
    end
    repeat (2) @(posedge clk);
    #2;
    if (msgs_seen != seen_start) report_failure("message produced by a local write");
    finish_test("local memory");

    // 3. Broadcast region writes
    seen_start = msgs_seen;
    for (int i = 0; i < 6; i++) begin
      wd = next_rand();
      core_access(1'b1, wd[3:0], 16'(BC_BASE + (next_rand() % BC_REGION_WORDS)),
                  next_rand(), rd);
    end
    wait_msgs_drained();
    if (msgs_seen != seen_start + 6) report_mismatch("message count", seen_start + 6,
                                                     msgs_seen);
    finish_test("broadcast writes");

    // 4. Back-pressure from a full message FIFO
    seen_start       = msgs_seen;
    bc_msg_out_ready = 1'b0;
    for (int i = 0; i < MSG_FIFO_DEPTH; i++) begin
      core_access(1'b1, 4'hf, 16'(BC_BASE + i), next_rand(), rd);
    end
    if (core_mem_ready !== 1'b0) report_mismatch("core_mem_ready", 0, core_mem_ready);
    fork
      core_access(1'b1, 4'h3, 16'(BC_BASE + 10), next_rand(), rd);
      begin
        repeat (3) begin
          @(posedge clk);
          if (core_mem_ready !== 1'b0) report_mismatch("core_mem_ready", 0, core_mem_ready);
        end
        #2 bc_msg_out_ready = 1'b1;
      end
    join
    core_access(1'b1, 4'hc, 16'(BC_BASE + 11), next_rand(), rd);
    wait_msgs_drained();
    if (msgs_seen != seen_start + MSG_FIFO_DEPTH + 2) begin
      report_mismatch("message count", seen_start + MSG_FIFO_DEPTH + 2, msgs_seen);
    end
    finish_test("back-pressure");

    // 5. Incoming messages merged into the region
    for (int i = 0; i < 4; i++) begin
      core_access(1'b1, 4'hf, 16'(BC_BASE + i * 7), next_rand(), rd);
    end
    wait_msgs_drained();
    for (int i = 0; i < 4; i++) begin
      wd                     = next_rand();
      bc_msg_in.offset       = 8'(i * 7);
      bc_msg_in.strb         = wd[3:0];
      bc_msg_in.data         = next_rand();
      bc_msg_in_valid        = 1'b1;
      @(posedge clk);
      model[BC_BASE + i * 7] = merge_bytes(model[BC_BASE + i * 7], bc_msg_in.data,
                                           bc_msg_in.strb);
      #2 bc_msg_in_valid = 1'b0;
      core_access(1'b0, 4'h0, 16'(BC_BASE + i * 7), '0, rd);
      if (rd !== model[BC_BASE + i * 7]) begin
        report_mismatch("core_mem_rd_data", model[BC_BASE + i * 7], rd);
      end
    end
    finish_test("incoming messages");

    // 6. Status stream
    cfg = next_rand();
    apb_xfer(1'b1, 4'h0, cfg, rd, err);
    if (core_status_addr !== core_block_pkg::STAT_CFG) begin
      report_mismatch("core_status_addr", core_block_pkg::STAT_CFG, core_status_addr);
    end
    if (core_status_data !== idle_word(cfg[31:24], 1'b0, 1'b0)) begin
      report_mismatch("core_status_data", idle_word(cfg[31:24], 1'b0, 1'b0), core_status_data);
    end
    bc_msg_out_ready = 1'b0;
    for (int i = 0; i < MSG_FIFO_DEPTH; i++) begin
      core_access(1'b1, 4'hf, 16'(BC_BASE + 20 + i), next_rand(), rd);
    end
    if (core_status_data !== idle_word(cfg[31:24], 1'b1, 1'b0)) begin
      report_mismatch("core_status_data", idle_word(cfg[31:24], 1'b1, 1'b0), core_status_data);
    end
    bc_msg_out_ready = 1'b1;
    wait_msgs_drained();
    for (int i = 0; i < SLOT_FIFO_DEPTH; i++) begin
      slot_push(next_rand());
      if (core_status_addr !== core_block_pkg::STAT_SLOTS) begin
        report_mismatch("core_status_addr", core_block_pkg::STAT_SLOTS, core_status_addr);
      end
      if (core_status_data !== exp_slots[0]) begin
        report_mismatch("core_status_data", exp_slots[0], core_status_data);
      end
    end
    if (slot_wr_ready !== 1'b0) report_mismatch("slot_wr_ready", 0, slot_wr_ready);
    cycles = 0;
    while (exp_slots.size() != 0) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("slot reports to drain");
      @(posedge clk);
      if (core_status_addr !== core_block_pkg::STAT_SLOTS) begin
        report_mismatch("core_status_addr", core_block_pkg::STAT_SLOTS, core_status_addr);
      end
      if (core_status_data !== exp_slots[0]) begin
        report_mismatch("core_status_data", exp_slots[0], core_status_data);
      end
      if (core_status_ready) void'(exp_slots.pop_front());
      #2 core_status_ready = !core_status_ready;
    end
    core_status_ready = 1'b0;
    if (core_status_addr !== core_block_pkg::STAT_CFG) begin
      report_mismatch("core_status_addr", core_block_pkg::STAT_CFG, core_status_addr);
    end
    if (core_status_data !== idle_word(cfg[31:24], 1'b0, 1'b0)) begin
      report_mismatch("core_status_data", idle_word(cfg[31:24], 1'b0, 1'b0), core_status_data);
    end
    finish_test("status stream");

    $display("Finished %0d tests, error count %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
source/core_block_pkg.sv
source/payload_fifo.sv
source/bc_region_encoder.sv
source/data_mem.sv
source/block_status_ctrl.sv
source/core_block.sv
verif/core_block_tb.sv

/* Bender.yml */
package:
  name: core_block

sources:
  - source/core_block_pkg.sv
  - source/payload_fifo.sv
  - source/bc_region_encoder.sv
  - source/data_mem.sv
  - source/block_status_ctrl.sv
  - source/core_block.sv
  - target: test
    files:
      - verif/core_block_tb.sv
